// File: verilog/fir_pkg.sv
package fir_pkg;

    // ============================================================
    // filter datapath constants
    // ============================================================
    localparam int DATA_W        = 32;  // sample, coefficient and result width
    localparam int NTAPS_DEFAULT = 11;

    // saturation limits for signed DATA_W
    localparam logic signed [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // one stream beat, used on both streams and inside the core
    typedef struct packed {
        logic signed [DATA_W-1:0] data;
        logic                     last;
    } sample_t;

    // ============================================================
    // control FSM
    // ============================================================
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_FETCH  = 3'd1,  // waiting for an input sample
        ST_CALC   = 3'd2,  // one tap per cycle
        ST_OUT    = 3'd3,  // result held until the sink takes it
        ST_FINISH = 3'd4
    } ctrl_state_e;

endpackage

// File: verilog/axil_pkg.sv
package axil_pkg;

    // ============================================================
    // register map
    // ============================================================
    localparam int ADDR_W = 12;

    localparam logic [ADDR_W-1:0] ADDR_CTRL     = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_LENGTH   = 12'h010;
    localparam logic [ADDR_W-1:0] ADDR_TAP_BASE = 12'h020;  // tap k at base + 4k
    localparam logic [ADDR_W-1:0] ADDR_TAP_LAST = 12'h0FF;

    // control / status bits at ADDR_CTRL
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_DONE_BIT  = 1;
    localparam int CTRL_IDLE_BIT  = 2;

    localparam logic [fir_pkg::DATA_W-1:0] READ_UNMAPPED = '1;

    // ============================================================
    // AXI4-Lite channels, no write response channel
    // ============================================================
    typedef struct packed {
        logic                       awvalid;
        logic [ADDR_W-1:0]          awaddr;
        logic                       wvalid;
        logic [fir_pkg::DATA_W-1:0] wdata;
        logic                       arvalid;
        logic [ADDR_W-1:0]          araddr;
        logic                       rready;
    } axil_req_t;

    typedef struct packed {
        logic                       awready;
        logic                       wready;
        logic                       arready;
        logic                       rvalid;
        logic [fir_pkg::DATA_W-1:0] rdata;
    } axil_rsp_t;

endpackage

// File: verilog/sample_buffer.sv
module sample_buffer #(
    parameter  int NTAPS = fir_pkg::NTAPS_DEFAULT,
    localparam int IDX_W = $clog2(NTAPS + 1)
) (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              clear,
    input  logic                              push,
    input  logic signed [fir_pkg::DATA_W-1:0] push_sample,
    input  logic        [IDX_W-1:0]           tap_idx,
    output logic signed [fir_pkg::DATA_W-1:0] hist_data
);
    logic signed [fir_pkg::DATA_W-1:0] mem [NTAPS];
    logic        [IDX_W-1:0]           wr_ptr;  // next slot to write
    logic        [IDX_W-1:0]           fill;    // pushes since clear, stops at NTAPS
    logic        [IDX_W:0]             rd_sum;
    logic        [IDX_W-1:0]           rd_ptr;

    // age 0 is the newest sample, one slot behind wr_ptr
    assign rd_sum    = {1'b0, wr_ptr} + (IDX_W+1)'(NTAPS - 1) - {1'b0, tap_idx};
    assign rd_ptr    = (rd_sum >= NTAPS) ? IDX_W'(rd_sum - NTAPS) : IDX_W'(rd_sum);
    assign hist_data = (tap_idx < fill) ? mem[rd_ptr] : '0;

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
            fill   <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            fill   <= '0;
        end else if (push) begin
            wr_ptr <= (wr_ptr == IDX_W'(NTAPS - 1)) ? '0 : wr_ptr + 1'b1;
            if (fill != IDX_W'(NTAPS)) begin
                fill <= fill + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_sample;
        end
    end

endmodule

// File: verilog/fir_mac.sv
module fir_mac (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              mac_clear,
    input  logic                              mac_en,
    input  logic signed [fir_pkg::DATA_W-1:0] coef,
    input  logic signed [fir_pkg::DATA_W-1:0] sample,
    output logic signed [fir_pkg::DATA_W-1:0] acc
);
    localparam int W = fir_pkg::DATA_W;

    logic signed [2*W-1:0] prod_full;
    logic signed [W-1:0]   prod_sat;
    logic signed [W:0]     sum_full;
    logic signed [W-1:0]   sum_sat;

    assign prod_full = coef * sample;  // full width, no overflow here

    // ============================================================
    // saturate product, then saturate running sum
    // ============================================================
    always_comb begin
        if (prod_full > fir_pkg::SAT_MAX) begin
            prod_sat = fir_pkg::SAT_MAX;
        end else if (prod_full < fir_pkg::SAT_MIN) begin
            prod_sat = fir_pkg::SAT_MIN;
        end else begin
            prod_sat = prod_full[W-1:0];
        end
    end

    assign sum_full = {acc[W-1], acc} + {prod_sat[W-1], prod_sat};

    always_comb begin
        if (sum_full[W] != sum_full[W-1]) begin
            sum_sat = sum_full[W] ? fir_pkg::SAT_MIN : fir_pkg::SAT_MAX;  // sign bit picks side
        end else begin
            sum_sat = sum_full[W-1:0];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            acc <= '0;
        end else if (mac_clear) begin
            acc <= '0;
        end else if (mac_en) begin
            acc <= sum_sat;
        end
    end

endmodule

// File: verilog/axil_regs.sv
module axil_regs #(
    parameter  int NTAPS = fir_pkg::NTAPS_DEFAULT,
    localparam int IDX_W = $clog2(NTAPS + 1)
) (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  axil_pkg::axil_req_t               bus_req,
    output axil_pkg::axil_rsp_t               bus_rsp,
    input  logic        [IDX_W-1:0]           tap_idx,
    input  logic                              done,
    output logic                              start,
    output logic signed [fir_pkg::DATA_W-1:0] tap_coef
);
    localparam int AW = axil_pkg::ADDR_W;

    logic                              awready_q;  // drives awready and wready together
    logic                              arready_q;
    logic                              rvalid_q;
    logic        [fir_pkg::DATA_W-1:0] rdata_q;
    logic                              ap_done;
    logic                              ap_idle;
    logic        [fir_pkg::DATA_W-1:0] data_length;
    logic                              len_written;
    logic        [NTAPS-1:0]           tap_written;
    logic signed [fir_pkg::DATA_W-1:0] taps [NTAPS];
    logic                              wr_en;
    logic                              rd_en;
    logic                              wr_in_win;
    logic                              rd_in_win;
    logic                              start_ok;
    logic        [fir_pkg::DATA_W-1:0] rd_word;

    function automatic logic [AW-1:0] tap_addr(input int k);
        return axil_pkg::ADDR_TAP_BASE + AW'(4 * k);
    endfunction

    assign bus_rsp = '{awready: awready_q, wready: awready_q, arready: arready_q,
                       rvalid: rvalid_q, rdata: rdata_q};

    assign wr_en = awready_q && bus_req.awvalid && bus_req.wvalid;
    assign rd_en = arready_q && bus_req.arvalid;

    assign wr_in_win = (bus_req.awaddr >= axil_pkg::ADDR_TAP_BASE) &&
                       (bus_req.awaddr <= axil_pkg::ADDR_TAP_LAST);
    assign rd_in_win = (bus_req.araddr >= axil_pkg::ADDR_TAP_BASE) &&
                       (bus_req.araddr <= axil_pkg::ADDR_TAP_LAST);

    // a run may start only with every register written since the last run
    assign start_ok = wr_en && (bus_req.awaddr == axil_pkg::ADDR_CTRL) &&
                      bus_req.wdata[axil_pkg::CTRL_START_BIT] &&
                      ap_idle && len_written && (&tap_written);

    assign tap_coef = taps[tap_idx];

    // ============================================================
    // read mux
    // ============================================================
    always_comb begin
        rd_word = axil_pkg::READ_UNMAPPED;
        if (bus_req.araddr == axil_pkg::ADDR_CTRL) begin
            rd_word = '0;
            rd_word[axil_pkg::CTRL_START_BIT] = 1'b0;  // start is write-only
            rd_word[axil_pkg::CTRL_DONE_BIT]  = ap_done;
            rd_word[axil_pkg::CTRL_IDLE_BIT]  = ap_idle;
        end else if (bus_req.araddr == axil_pkg::ADDR_LENGTH) begin
            rd_word = data_length;
        end else if (rd_in_win) begin
            for (int k = 0; k < NTAPS; k++) begin
                if (bus_req.araddr == tap_addr(k)) begin
                    rd_word = taps[k];
                end
            end
        end
    end

    // ============================================================
    // handshakes and control state
    // ============================================================
    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            awready_q   <= 1'b0;
            arready_q   <= 1'b0;
            rvalid_q    <= 1'b0;
            start       <= 1'b0;
            ap_done     <= 1'b0;
            ap_idle     <= 1'b1;
            data_length <= '0;
            len_written <= 1'b0;
            tap_written <= '0;
        end else begin
            awready_q <= bus_req.awvalid && bus_req.wvalid && !awready_q;
            arready_q <= bus_req.arvalid && !arready_q && !rvalid_q;  // one read in flight

            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && bus_req.rready) begin
                rvalid_q <= 1'b0;
            end

            start <= start_ok;
            if (start_ok) begin
                ap_idle <= 1'b0;
            end
            if (rd_en && bus_req.araddr == axil_pkg::ADDR_CTRL) begin
                ap_done <= 1'b0;  // clear on read
            end

            if (wr_en && ap_idle && bus_req.awaddr == axil_pkg::ADDR_LENGTH) begin
                data_length <= bus_req.wdata;
                len_written <= 1'b1;
            end
            for (int k = 0; k < NTAPS; k++) begin
                if (wr_en && ap_idle && wr_in_win && bus_req.awaddr == tap_addr(k)) begin
                    tap_written[k] <= 1'b1;
                end
            end

            // end of run, set after the read clear so a late done is not lost
            if (done) begin
                ap_done     <= 1'b1;
                ap_idle     <= 1'b1;
                len_written <= 1'b0;
                tap_written <= '0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_en) begin
            rdata_q <= rd_word;
        end
        for (int k = 0; k < NTAPS; k++) begin
            if (wr_en && ap_idle && wr_in_win && bus_req.awaddr == tap_addr(k)) begin
                taps[k] <= bus_req.wdata;
            end
        end
    end

endmodule

// File: verilog/fir_ctrl.sv
module fir_ctrl #(
    parameter  int NTAPS = fir_pkg::NTAPS_DEFAULT,
    localparam int IDX_W = $clog2(NTAPS + 1)
) (
    input  logic                              axis_clk,
    input  logic                              axis_rst_n,
    input  logic                              start,
    input  logic                              ss_tvalid,
    input  fir_pkg::sample_t                  ss_sample,
    input  logic                              sm_tready,
    input  logic signed [fir_pkg::DATA_W-1:0] acc,
    output logic                              ss_tready,
    output logic                              sm_tvalid,
    output fir_pkg::sample_t                  sm_sample,
    output logic        [IDX_W-1:0]           tap_idx,
    output logic                              push,
    output logic signed [fir_pkg::DATA_W-1:0] push_sample,
    output logic                              clear,
    output logic                              mac_clear,
    output logic                              mac_en,
    output logic                              done
);
    fir_pkg::ctrl_state_e state;
    fir_pkg::ctrl_state_e state_next;

    logic accept;    // input beat taken this cycle
    logic out_xfer;  // output beat taken this cycle
    logic last_tap;
    logic cur_last;  // last flag of the sample being processed
    logic load_out;

    assign accept   = (state == fir_pkg::ST_FETCH) && ss_tvalid;
    assign out_xfer = sm_tvalid && sm_tready;
    assign last_tap = (tap_idx == IDX_W'(NTAPS - 1));
    assign load_out = (state == fir_pkg::ST_OUT) && !sm_tvalid;

    assign ss_tready   = (state == fir_pkg::ST_FETCH);
    assign push        = accept;
    assign push_sample = ss_sample.data;
    assign clear       = start;  // fresh history for every run
    assign mac_clear   = accept;
    assign mac_en      = (state == fir_pkg::ST_CALC);
    assign done        = (state == fir_pkg::ST_FINISH);

    // ============================================================
    // next state
    // ============================================================
    always_comb begin
        state_next = state;
        case (state)
            fir_pkg::ST_IDLE: begin
                if (start) begin
                    state_next = fir_pkg::ST_FETCH;
                end
            end
            fir_pkg::ST_FETCH: begin
                if (ss_tvalid) begin
                    state_next = fir_pkg::ST_CALC;
                end
            end
            fir_pkg::ST_CALC: begin
                if (last_tap) begin
                    state_next = fir_pkg::ST_OUT;
                end
            end
            fir_pkg::ST_OUT: begin
                if (out_xfer) begin
                    state_next = cur_last ? fir_pkg::ST_FINISH : fir_pkg::ST_FETCH;
                end
            end
            fir_pkg::ST_FINISH: state_next = fir_pkg::ST_IDLE;
            default:            state_next = fir_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge axis_clk) begin
        if (!axis_rst_n) begin
            state     <= fir_pkg::ST_IDLE;
            tap_idx   <= '0;
            sm_tvalid <= 1'b0;
        end else begin
            state <= state_next;

            if (accept) begin
                tap_idx <= '0;
            end else if (mac_en && !last_tap) begin
                tap_idx <= tap_idx + 1'b1;
            end

            // acc settles one cycle into ST_OUT, then valid rises
            if (load_out) begin
                sm_tvalid <= 1'b1;
            end else if (out_xfer) begin
                sm_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (accept) begin
            cur_last <= ss_sample.last;
        end
        if (load_out) begin
            sm_sample <= '{data: acc, last: cur_last};
        end
    end

endmodule

// File: verilog/fir_top.sv
module fir_top #(
    parameter int NTAPS = fir_pkg::NTAPS_DEFAULT
) (
    input  logic                axis_clk,
    input  logic                axis_rst_n,
    input  axil_pkg::axil_req_t bus_req,
    output axil_pkg::axil_rsp_t bus_rsp,
    input  logic                ss_tvalid,
    input  fir_pkg::sample_t    ss_sample,
    output logic                ss_tready,
    output logic                sm_tvalid,
    output fir_pkg::sample_t    sm_sample,
    input  logic                sm_tready
);
    localparam int IDX_W = $clog2(NTAPS + 1);

    logic                              start;
    logic                              done;
    logic        [IDX_W-1:0]           tap_idx;
    logic signed [fir_pkg::DATA_W-1:0] tap_coef;
    logic signed [fir_pkg::DATA_W-1:0] hist_data;
    logic                              push;
    logic signed [fir_pkg::DATA_W-1:0] push_sample;
    logic                              clear;
    logic                              mac_clear;
    logic                              mac_en;
    logic signed [fir_pkg::DATA_W-1:0] acc;

    axil_regs #(.NTAPS(NTAPS)) u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .tap_idx    (tap_idx),
        .done       (done),
        .start      (start),
        .tap_coef   (tap_coef)
    );

    fir_ctrl #(.NTAPS(NTAPS)) u_ctrl (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start       (start),
        .ss_tvalid   (ss_tvalid),
        .ss_sample   (ss_sample),
        .sm_tready   (sm_tready),
        .acc         (acc),
        .ss_tready   (ss_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_sample   (sm_sample),
        .tap_idx     (tap_idx),
        .push        (push),
        .push_sample (push_sample),
        .clear       (clear),
        .mac_clear   (mac_clear),
        .mac_en      (mac_en),
        .done        (done)
    );

    sample_buffer #(.NTAPS(NTAPS)) u_hist (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .clear       (clear),
        .push        (push),
        .push_sample (push_sample),
        .tap_idx     (tap_idx),
        .hist_data   (hist_data)
    );

    fir_mac u_mac (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .mac_clear  (mac_clear),
        .mac_en     (mac_en),
        .coef       (tap_coef),
        .sample     (hist_data),
        .acc        (acc)
    );

endmodule

// File: dv/fir_checker.sv
module fir_checker (
    input logic             axis_clk,
    input logic             axis_rst_n,
    input logic             ss_tready,
    input logic             sm_tvalid,
    input fir_pkg::sample_t sm_sample,
    input logic             sm_tready,
    input logic             done
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;  // read by the testbench at the end

    // ============================================================
    // stream and control rules
    // ============================================================
    a_out_hold: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_sample))
    else begin
        assert_fails++;
        $error("output beat dropped or changed before sm_tready");
    end

    a_no_overlap: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        !(ss_tready && sm_tvalid))
    else begin
        assert_fails++;
        $error("ss_tready and sm_tvalid high in the same cycle");
    end

    a_done_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        done |=> !done)
    else begin
        assert_fails++;
        $error("done held for more than one cycle");
    end

endmodule

bind fir_ctrl fir_checker u_checker (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_sample  (sm_sample),
    .sm_tready  (sm_tready),
    .done       (done)
);

// File: dv/fir_tb.sv
module fir_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NTAPS = fir_pkg::NTAPS_DEFAULT;
    localparam int W     = fir_pkg::DATA_W;
    localparam int NRUNS = 5;
    localparam int MAXS  = 16;  // samples per table row, at most
    localparam logic [W-1:0] MAXV = fir_pkg::SAT_MAX;
    localparam logic [W-1:0] MINV = fir_pkg::SAT_MIN;

    logic                axis_clk;
    logic                axis_rst_n;
    axil_pkg::axil_req_t bus_req;
    axil_pkg::axil_rsp_t bus_rsp;
    logic                ss_tvalid;
    fir_pkg::sample_t    ss_sample;
    logic                ss_tready;
    logic                sm_tvalid;
    fir_pkg::sample_t    sm_sample;
    logic                sm_tready;

    // stimulus table, one row per run
    logic signed [W-1:0] tab_taps [NRUNS][NTAPS];
    logic signed [W-1:0] tab_x    [NRUNS][MAXS];
    logic                tab_last [NRUNS][MAXS];
    logic signed [W-1:0] tab_y    [NRUNS][MAXS];
    int                  tab_count[NRUNS];
    bit                  tab_stall[NRUNS];  // random sm_tready
    bit                  tab_hand [NRUNS];  // expected values entered by hand

    int           seed = 32'h8b85;
    int           err_count;
    int           check_count;
    int           cycle_count;
    int           timeout_limit;
    logic [W-1:0] rd_val;

    fir_top #(.NTAPS(NTAPS)) u_dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .ss_tvalid  (ss_tvalid),
        .ss_sample  (ss_sample),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_sample  (sm_sample),
        .sm_tready  (sm_tready)
    );

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("run timed out after %0d cycles, the DUT stopped responding", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ============================================================
    // checks and reference model
    // ============================================================
    task automatic check_value(input string what, input logic [W-1:0] got,
                               input logic [W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("CHECK FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic signed [W-1:0] clip(input longint v);
        if (v > longint'(fir_pkg::SAT_MAX)) begin
            return fir_pkg::SAT_MAX;
        end
        if (v < longint'(fir_pkg::SAT_MIN)) begin
            return fir_pkg::SAT_MIN;
        end
        return v[W-1:0];
    endfunction

    // y[n] = sum of h[k] * x[n-k], each product and each partial sum clipped
    function automatic logic signed [W-1:0] model_output(input int r, input int n);
        longint sum;
        longint x;
        sum = 0;
        for (int k = 0; k < NTAPS; k++) begin
            x = 0;
            if (n - k >= 0) begin
                x = longint'(tab_x[r][n-k]);
            end
            sum = longint'(clip(sum + longint'(clip(longint'(tab_taps[r][k]) * x))));
        end
        return sum[W-1:0];
    endfunction

    function automatic logic [W-1:0] status_word(input bit done, input bit idle);
        logic [W-1:0] v;
        v = '0;
        v[axil_pkg::CTRL_DONE_BIT] = done;
        v[axil_pkg::CTRL_IDLE_BIT] = idle;
        return v;
    endfunction

    function automatic logic [axil_pkg::ADDR_W-1:0] tap_reg_addr(input int k);
        return axil_pkg::ADDR_TAP_BASE + 12'(4 * k);
    endfunction

    task automatic hand_entry(input int r, input int n, input logic [W-1:0] x,
                              input logic [W-1:0] y);
        tab_x[r][n] = x;
        tab_y[r][n] = y;
    endtask

    task automatic fill_table();
        for (int r = 0; r < NRUNS; r++) begin
            tab_hand[r]  = (r == 1 || r == 2);
            tab_stall[r] = (r >= 3);
            tab_count[r] = tab_hand[r] ? 4 : ((r == 4) ? 12 : MAXS);
            for (int k = 0; k < NTAPS; k++) begin
                if (tab_hand[r]) begin
                    tab_taps[r][k] = MAXV;
                end else if (r == 4) begin
                    tab_taps[r][k] = $random(seed);  // full width, saturates often
                end else begin
                    tab_taps[r][k] = $random(seed) % 256;
                end
            end
            for (int n = 0; n < MAXS; n++) begin
                if (r == 4) begin
                    tab_x[r][n] = $random(seed);
                end else begin
                    tab_x[r][n] = $random(seed) % 4096;
                end
                tab_last[r][n] = (n == tab_count[r] - 1);
                tab_y[r][n]    = '0;
            end
        end
        // full scale taps, worked out by hand in k order
        hand_entry(1, 0, MAXV, MAXV);
        hand_entry(1, 1, MAXV, MAXV);
        hand_entry(1, 2, MINV, 32'h7fff_fffe);
        hand_entry(1, 3, MINV, 32'h7fff_fffe);
        hand_entry(2, 0, MINV, MINV);
        hand_entry(2, 1, MINV, MINV);
        hand_entry(2, 2, MAXV, MINV);
        hand_entry(2, 3, MAXV, MINV);
        for (int r = 0; r < NRUNS; r++) begin
            for (int n = 0; n < tab_count[r] && !tab_hand[r]; n++) begin
                tab_y[r][n] = model_output(r, n);
            end
        end
    endtask

    // ============================================================
    // bus tasks, called on a falling edge
    // ============================================================
    task automatic bus_write(input logic [axil_pkg::ADDR_W-1:0] addr, input logic [W-1:0] data);
        bus_req.awvalid = 1'b1;
        bus_req.awaddr  = addr;
        bus_req.wvalid  = 1'b1;
        bus_req.wdata   = data;
        @(negedge axis_clk);
        while (!bus_rsp.awready) @(negedge axis_clk);
        check_value("wready with awready", 32'(bus_rsp.wready), 32'h1);
        @(negedge axis_clk);  // write taken at the edge just passed
        bus_req.awvalid = 1'b0;
        bus_req.wvalid  = 1'b0;
        check_value("awready after the write", 32'(bus_rsp.awready), '0);
        check_value("wready after the write", 32'(bus_rsp.wready), '0);
    endtask

    task automatic bus_read(input logic [axil_pkg::ADDR_W-1:0] addr, output logic [W-1:0] data);
        bus_req.arvalid = 1'b1;
        bus_req.araddr  = addr;
        @(negedge axis_clk);
        while (!bus_rsp.arready) @(negedge axis_clk);
        @(negedge axis_clk);
        bus_req.arvalid = 1'b0;
        while (!bus_rsp.rvalid) @(negedge axis_clk);
        data           = bus_rsp.rdata;
        bus_req.rready = 1'b1;
        @(negedge axis_clk);
        bus_req.rready = 1'b0;
    endtask

    task automatic read_expect(input logic [axil_pkg::ADDR_W-1:0] addr,
                               input logic [W-1:0] exp, input string what);
        bus_read(addr, rd_val);
        check_value(what, rd_val, exp);
    endtask

    task automatic check_refused_start(input string what);
        bus_write(axil_pkg::ADDR_CTRL, 32'h1 << axil_pkg::CTRL_START_BIT);
        ss_tvalid = 1'b1;
        ss_sample = '{data: 32'h5a5a, last: 1'b1};
        repeat (8) begin
            @(negedge axis_clk);
            check_value({what, ", ss_tready"}, 32'(ss_tready), '0);
            check_value({what, ", sm_tvalid"}, 32'(sm_tvalid), '0);
        end
        ss_tvalid = 1'b0;
        read_expect(axil_pkg::ADDR_CTRL, status_word(1'b0, 1'b1), {what, ", status"});
    endtask

    // ============================================================
    // streams and runs
    // ============================================================
    task automatic feed_samples(input int r);
        for (int n = 0; n < tab_count[r]; n++) begin
            ss_tvalid = 1'b1;
            ss_sample = '{data: tab_x[r][n], last: tab_last[r][n]};
            while (!ss_tready) @(negedge axis_clk);
            @(negedge axis_clk);  // accepted at the edge just passed
        end
        ss_tvalid = 1'b0;
    endtask

    task automatic collect_results(input int r);
        int n;
        n = 0;
        while (n < tab_count[r]) begin
            @(negedge axis_clk);
            sm_tready = tab_stall[r] ? (($random(seed) & 1) == 1) : 1'b1;
            if (sm_tvalid && sm_tready) begin
                check_value($sformatf("run %0d output %0d data", r, n),
                            sm_sample.data, tab_y[r][n]);
                check_value($sformatf("run %0d output %0d last", r, n),
                            32'(sm_sample.last), 32'(tab_last[r][n]));
                n++;
            end
        end
        @(negedge axis_clk);
        sm_tready = 1'b0;
    endtask

    task automatic apply_run(input int r);
        bus_write(axil_pkg::ADDR_LENGTH, 32'(tab_count[r]));
        for (int k = 0; k < NTAPS; k++) begin
            bus_write(tap_reg_addr(k), tab_taps[r][k]);
        end
        read_expect(axil_pkg::ADDR_LENGTH, 32'(tab_count[r]), "data length readback");
        for (int k = 0; k < NTAPS; k++) begin
            read_expect(tap_reg_addr(k), tab_taps[r][k], $sformatf("tap %0d readback", k));
        end
        bus_write(axil_pkg::ADDR_CTRL, 32'h1 << axil_pkg::CTRL_START_BIT);
        fork
            feed_samples(r);
            collect_results(r);
        join
        repeat (2) @(negedge axis_clk);  // done lands one cycle after the last output
        read_expect(axil_pkg::ADDR_CTRL, status_word(1'b1, 1'b1), "status after run");
        read_expect(axil_pkg::ADDR_CTRL, status_word(1'b0, 1'b1), "status second read");
        check_refused_start("restart without rewrite");
    endtask

    initial begin
        int total;
        axis_rst_n  = 1'b0;
        bus_req     = '0;
        ss_tvalid   = 1'b0;
        ss_sample   = '0;
        sm_tready   = 1'b0;
        err_count   = 0;
        check_count = 0;
        cycle_count = 0;
        fill_table();
        total = 0;
        for (int r = 0; r < NRUNS; r++) begin
            total += tab_count[r];
        end
        timeout_limit = total * (NTAPS + 16) + 2000;

        repeat (8) @(negedge axis_clk);
        axis_rst_n = 1'b1;
        @(negedge axis_clk);

        read_expect(axil_pkg::ADDR_CTRL, status_word(1'b0, 1'b1), "status after reset");
        check_value("sm_tvalid after reset", 32'(sm_tvalid), '0);

        bus_write(axil_pkg::ADDR_LENGTH, 32'h0000_1234);
        read_expect(axil_pkg::ADDR_LENGTH, 32'h0000_1234, "data length readback");
        for (int k = 0; k < NTAPS - 1; k++) begin  // last tap left unwritten
            bus_write(tap_reg_addr(k), 32'hc0ef_0000 + 32'(k));
        end
        for (int k = 0; k < NTAPS - 1; k++) begin
            read_expect(tap_reg_addr(k), 32'hc0ef_0000 + 32'(k), $sformatf("tap %0d", k));
        end
        read_expect(12'h004, axil_pkg::READ_UNMAPPED, "unmapped address");
        read_expect(tap_reg_addr(NTAPS), axil_pkg::READ_UNMAPPED, "tap beyond NTAPS");
        check_refused_start("start with one tap unwritten");

        for (int r = 0; r < NRUNS; r++) begin
            apply_run(r);
        end

        $display("checks run %0d, checks failed %0d, assertion failures %0d",
                 check_count, err_count, u_dut.u_ctrl.u_checker.assert_fails);
        if (err_count == 0 && u_dut.u_ctrl.u_checker.assert_fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/fir_pkg.sv
verilog/axil_pkg.sv
verilog/sample_buffer.sv
verilog/fir_mac.sv
verilog/axil_regs.sv
verilog/fir_ctrl.sv
verilog/fir_top.sv
dv/fir_checker.sv
dv/fir_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= fir_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
